// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;                          // Integer register width

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [1:0] ALU_OP_ADD    = 2'b00;      // Address and link sums
    localparam logic [1:0] ALU_OP_BRANCH = 2'b01;      // Compare for branches
    localparam logic [1:0] ALU_OP_FUNCT  = 2'b10;      // Decoded from funct3/funct7
    localparam logic [1:0] ALU_OP_LUI    = 2'b11;      // Immediate straight through

    localparam logic [3:0] ALU_ADD    = 4'd0;
    localparam logic [3:0] ALU_SUB    = 4'd1;
    localparam logic [3:0] ALU_SLL    = 4'd2;
    localparam logic [3:0] ALU_SLT    = 4'd3;
    localparam logic [3:0] ALU_SLTU   = 4'd4;
    localparam logic [3:0] ALU_XOR    = 4'd5;
    localparam logic [3:0] ALU_SRL    = 4'd6;
    localparam logic [3:0] ALU_SRA    = 4'd7;
    localparam logic [3:0] ALU_OR     = 4'd8;
    localparam logic [3:0] ALU_AND    = 4'd9;
    localparam logic [3:0] ALU_PASS_B = 4'd10;         // LUI result

    localparam logic [2:0] IMM_I = 3'd0;
    localparam logic [2:0] IMM_S = 3'd1;
    localparam logic [2:0] IMM_B = 3'd2;
    localparam logic [2:0] IMM_U = 3'd3;
    localparam logic [2:0] IMM_J = 3'd4;

    localparam logic [1:0] RES_ALU = 2'd0;             // Writeback from ALU
    localparam logic [1:0] RES_MEM = 2'd1;             // Writeback from load data
    localparam logic [1:0] RES_PC4 = 2'd2;             // Link address

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_rsi_t;

    // Immediate bits as B, U and J formats scatter them
    typedef struct packed {
        logic       sign;                              // Bit 31
        logic [5:0] imm_30_25;
        logic [3:0] imm_24_21;
        logic       imm_20;
        logic [7:0] imm_19_12;
        logic [3:0] imm_11_8;
        logic       imm_7;
        logic [6:0] opcode;
    } instr_buj_t;

    typedef union packed {
        instr_rsi_t rsi;
        instr_buj_t buj;
    } instr_t;

endpackage

`default_nettype wire

// ==== logic/alu_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_decoder (
    input  logic [1:0] alu_op_i,
    input  logic [2:0] funct3_i,
    input  logic [6:0] funct7_i,
    output logic [3:0] alu_control_o
);

    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_OP_ADD:    alu_control_o = rv_pkg::ALU_ADD;
            rv_pkg::ALU_OP_BRANCH: begin
                // BLTU and BGEU compare unsigned, the rest subtract
                alu_control_o = (funct3_i[2:1] == 2'b11) ? rv_pkg::ALU_SLTU : rv_pkg::ALU_SUB;
            end
            rv_pkg::ALU_OP_FUNCT: begin
                case (funct3_i)
                    // Only R-type reaches 000 in this class
                    3'b000:  alu_control_o = funct7_i[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b001:  alu_control_o = rv_pkg::ALU_SLL;
                    3'b010:  alu_control_o = rv_pkg::ALU_SLT;
                    3'b011:  alu_control_o = rv_pkg::ALU_SLTU;
                    3'b100:  alu_control_o = rv_pkg::ALU_XOR;
                    3'b101:  alu_control_o = funct7_i[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'b110:  alu_control_o = rv_pkg::ALU_OR;
                    default: alu_control_o = rv_pkg::ALU_AND;
                endcase
            end
            default:               alu_control_o = rv_pkg::ALU_PASS_B;  // LUI
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/main_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module main_decoder (
    input  logic [6:0] opcode_i,
    input  logic [2:0] funct3_i,
    output logic       reg_wr_en_o,
    output logic       mem_wr_en_o,
    output logic [2:0] imm_src_o,
    output logic       alu_src_o,
    output logic       branch_o,
    output logic       jalr_o,
    output logic [1:0] result_src_o,
    output logic [1:0] alu_op_o,
    output logic [3:0] byte_en_o,
    output logic       alu_src_a_sel_o,
    output logic       signed_o
);

    logic [3:0] width_mask;                            // Access size from funct3

    always_comb begin
        case (funct3_i[1:0])
            2'b00:   width_mask = 4'b0001;             // Byte
            2'b01:   width_mask = 4'b0011;             // Half
            default: width_mask = 4'b1111;             // Word
        endcase
    end

    always_comb begin
        reg_wr_en_o     = 1'b0;
        mem_wr_en_o     = 1'b0;
        imm_src_o       = rv_pkg::IMM_I;
        alu_src_o       = 1'b0;
        branch_o        = 1'b0;
        jalr_o          = 1'b0;
        result_src_o    = rv_pkg::RES_ALU;
        alu_op_o        = rv_pkg::ALU_OP_ADD;
        byte_en_o       = 4'b0000;
        alu_src_a_sel_o = 1'b0;
        signed_o        = 1'b0;
        case (opcode_i)
            rv_pkg::OPC_LUI: begin
                reg_wr_en_o = 1'b1;
                imm_src_o   = rv_pkg::IMM_U;
                alu_src_o   = 1'b1;
                alu_op_o    = rv_pkg::ALU_OP_LUI;      // Pass immediate
            end
            rv_pkg::OPC_AUIPC: begin
                reg_wr_en_o     = 1'b1;
                imm_src_o       = rv_pkg::IMM_U;
                alu_src_o       = 1'b1;
                alu_src_a_sel_o = 1'b1;                // pc + imm
            end
            rv_pkg::OPC_JAL: begin
                reg_wr_en_o     = 1'b1;
                imm_src_o       = rv_pkg::IMM_J;
                alu_src_o       = 1'b1;
                branch_o        = 1'b1;
                result_src_o    = rv_pkg::RES_PC4;     // Link
                alu_src_a_sel_o = 1'b1;                // Sum not used for target
            end
            rv_pkg::OPC_JALR: begin
                reg_wr_en_o  = 1'b1;
                alu_src_o    = 1'b1;
                branch_o     = 1'b1;
                jalr_o       = 1'b1;                   // rs1 + imm target
                result_src_o = rv_pkg::RES_PC4;
            end
            rv_pkg::OPC_BRANCH: begin
                imm_src_o = rv_pkg::IMM_B;
                branch_o  = 1'b1;
                alu_op_o  = rv_pkg::ALU_OP_BRANCH;
            end
            rv_pkg::OPC_LOAD: begin
                reg_wr_en_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = rv_pkg::RES_MEM;
                byte_en_o    = width_mask;
                signed_o     = ~funct3_i[2];           // LBU and LHU zero-extend
            end
            rv_pkg::OPC_STORE: begin
                mem_wr_en_o = 1'b1;
                imm_src_o   = rv_pkg::IMM_S;
                alu_src_o   = 1'b1;
                byte_en_o   = width_mask;
            end
            rv_pkg::OPC_OP_IMM: begin
                reg_wr_en_o = 1'b1;
                alu_src_o   = 1'b1;
                // ADDI stays in the ADD class so imm bit 10 never reads as SUB
                alu_op_o    = (funct3_i == 3'b000) ? rv_pkg::ALU_OP_ADD : rv_pkg::ALU_OP_FUNCT;
            end
            rv_pkg::OPC_OP: begin
                reg_wr_en_o = 1'b1;
                alu_op_o    = rv_pkg::ALU_OP_FUNCT;    // Register form
            end
            default: ;                                 // Unsupported opcodes do nothing
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  logic [6:0]              opcode_i,
    input  logic [2:0]              funct3_i,
    input  logic [6:0]              funct7_i,          // Bit 5 selects SUB and SRA
    input  logic                    zero_i,
    input  logic [rv_pkg::XLEN-1:0] alu_result_i,      // Compare result for branches
    output logic                    reg_wr_en_o,
    output logic                    mem_wr_en_o,
    output logic [2:0]              imm_src_o,
    output logic                    alu_src_o,         // Operand B is immediate
    output logic [1:0]              result_src_o,
    output logic [3:0]              alu_control_o,
    output logic                    pc_src_o,          // Take target instead of pc + 4
    output logic                    jalr_o,            // Target from ALU sum
    output logic [3:0]              byte_en_o,
    output logic                    alu_src_a_sel_o,   // Operand A is pc
    output logic                    signed_o
);

    logic [1:0] alu_op;                                // Class for the ALU decoder
    logic       branch;                                // Branch or jump instruction
    logic       branch_cond;                           // Compare outcome
    logic       jump;                                  // JAL or JALR

    main_decoder main_dec (
        .opcode_i       (opcode_i),
        .funct3_i       (funct3_i),
        .reg_wr_en_o    (reg_wr_en_o),
        .mem_wr_en_o    (mem_wr_en_o),
        .imm_src_o      (imm_src_o),
        .alu_src_o      (alu_src_o),
        .branch_o       (branch),
        .jalr_o         (jalr_o),
        .result_src_o   (result_src_o),
        .alu_op_o       (alu_op),
        .byte_en_o      (byte_en_o),
        .alu_src_a_sel_o(alu_src_a_sel_o),
        .signed_o       (signed_o)
    );

    alu_decoder alu_dec (
        .alu_op_i     (alu_op),
        .funct3_i     (funct3_i),
        .funct7_i     (funct7_i),
        .alu_control_o(alu_control_o)
    );

    always_comb begin
        case (funct3_i)
            3'b000:  branch_cond = zero_i;                       // BEQ
            3'b001:  branch_cond = ~zero_i;                      // BNE
            3'b100:  branch_cond = alu_result_i[rv_pkg::XLEN-1];  // BLT on negative difference
            3'b101:  branch_cond = ~alu_result_i[rv_pkg::XLEN-1]; // BGE on zero or above
            3'b110:  branch_cond = (alu_result_i == 32'd1);      // BLTU via SLTU
            3'b111:  branch_cond = (alu_result_i == 32'd0);      // BGEU via SLTU
            default: branch_cond = 1'b0;
        endcase
    end

    assign jump     = (opcode_i == rv_pkg::OPC_JAL) | (opcode_i == rv_pkg::OPC_JALR);
    assign pc_src_o = branch & (jump | branch_cond);     // Jumps always taken

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  rv_pkg::instr_t          instr_i,
    input  logic [2:0]              imm_src_i,
    output logic [rv_pkg::XLEN-1:0] imm_o
);

    logic sign;                                        // Bit 31 of every format

    assign sign = instr_i.buj.sign;

    always_comb begin
        case (imm_src_i)
            rv_pkg::IMM_S: imm_o = {{20{sign}}, instr_i.rsi.funct7, instr_i.rsi.rd};
            rv_pkg::IMM_B: imm_o = {{20{sign}}, instr_i.buj.imm_7, instr_i.buj.imm_30_25,
                                    instr_i.buj.imm_11_8, 1'b0};
            rv_pkg::IMM_U: imm_o = {sign, instr_i.buj.imm_30_25, instr_i.buj.imm_24_21,
                                    instr_i.buj.imm_20, instr_i.buj.imm_19_12, 12'b0};
            rv_pkg::IMM_J: imm_o = {{12{sign}}, instr_i.buj.imm_19_12, instr_i.buj.imm_20,
                                    instr_i.buj.imm_30_25, instr_i.buj.imm_24_21, 1'b0};
            default:       imm_o = {{20{sign}}, instr_i.rsi.funct7, instr_i.rsi.rs2};  // I
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [rv_pkg::XLEN-1:0] a_i,
    input  logic [rv_pkg::XLEN-1:0] b_i,
    input  logic [3:0]              alu_control_i,
    output logic [rv_pkg::XLEN-1:0] result_o,
    output logic                    zero_o
);

    logic [4:0] shamt;                                 // Low five bits of B

    assign shamt = b_i[4:0];

    always_comb begin
        case (alu_control_i)
            rv_pkg::ALU_ADD:    result_o = a_i + b_i;
            rv_pkg::ALU_SUB:    result_o = a_i - b_i;
            rv_pkg::ALU_SLL:    result_o = a_i << shamt;
            rv_pkg::ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            rv_pkg::ALU_SLTU:   result_o = {31'b0, a_i < b_i};
            rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            rv_pkg::ALU_SRL:    result_o = a_i >> shamt;
            rv_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;     // Keeps sign bit
            rv_pkg::ALU_OR:     result_o = a_i | b_i;
            rv_pkg::ALU_AND:    result_o = a_i & b_i;
            rv_pkg::ALU_PASS_B: result_o = b_i;
            default:            result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic [4:0]              rs1_i,
    input  logic [4:0]              rs2_i,
    input  logic [4:0]              rd_i,
    input  logic                    wr_en_i,
    input  logic [rv_pkg::XLEN-1:0] wdata_i,
    output logic [rv_pkg::XLEN-1:0] rdata1_o,
    output logic [rv_pkg::XLEN-1:0] rdata2_o
);

    logic [rv_pkg::XLEN-1:0] regs [32];                // x0 is never written

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (rd_i != 5'd0)) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];  // Old value during write
    assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
    input  logic [rv_pkg::XLEN-1:0] addr_i,
    input  logic [rv_pkg::XLEN-1:0] store_data_i,
    input  logic [3:0]              byte_en_i,         // Width mask based at lane 0
    input  logic                    signed_i,
    input  logic                    mem_wr_en_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
    output logic [3:0]              dmem_be_o,
    output logic                    dmem_we_o,
    output logic [rv_pkg::XLEN-1:0] load_data_o
);

    logic [1:0]              lane;                     // Byte offset in word
    logic [rv_pkg::XLEN-1:0] rdata_shifted;            // Addressed byte at bit 0

    assign lane          = addr_i[1:0];
    assign dmem_we_o     = mem_wr_en_i;
    assign dmem_be_o     = mem_wr_en_i ? (byte_en_i << lane) : 4'b0000;
    assign dmem_wdata_o  = store_data_i << {lane, 3'b000};
    assign rdata_shifted = dmem_rdata_i >> {lane, 3'b000};

    always_comb begin
        case (byte_en_i)
            4'b0001: load_data_o = {{24{signed_i & rdata_shifted[7]}}, rdata_shifted[7:0]};
            4'b0011: load_data_o = {{16{signed_i & rdata_shifted[15]}}, rdata_shifted[15:0]};
            default: load_data_o = rdata_shifted;      // Word access at lane 0
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_unit (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    pc_src_i,          // Taken branch or jump
    input  logic                    jalr_i,
    input  logic [rv_pkg::XLEN-1:0] imm_i,
    input  logic [rv_pkg::XLEN-1:0] alu_result_i,      // rs1 + imm for JALR
    output logic [rv_pkg::XLEN-1:0] pc_o,
    output logic [rv_pkg::XLEN-1:0] pc_plus4_o
);

    logic [rv_pkg::XLEN-1:0] target;
    logic [rv_pkg::XLEN-1:0] pc_next;

    assign pc_plus4_o = pc_o + 32'd4;
    assign target     = jalr_i ? {alu_result_i[rv_pkg::XLEN-1:1], 1'b0} : pc_o + imm_i;
    assign pc_next    = pc_src_i ? target : pc_plus4_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_o <= '0;                                // Fetch starts at 0
        end else begin
            pc_o <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  logic        clk_i,
    input  logic        reset_i,
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_rdata_i,
    output logic [31:0] dmem_addr_o,
    output logic [31:0] dmem_wdata_o,
    output logic [3:0]  dmem_be_o,
    output logic        dmem_we_o,
    input  logic [31:0] dmem_rdata_i
);

    rv_pkg::instr_t          instr;                    // Fetched word in two views
    logic [rv_pkg::XLEN-1:0] pc;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] rdata1;
    logic [rv_pkg::XLEN-1:0] rdata2;
    logic [rv_pkg::XLEN-1:0] src_a;
    logic [rv_pkg::XLEN-1:0] src_b;
    logic [rv_pkg::XLEN-1:0] alu_result;
    logic [rv_pkg::XLEN-1:0] load_data;
    logic [rv_pkg::XLEN-1:0] result;                   // Writeback value
    logic                    zero;
    logic                    reg_wr_en;
    logic                    mem_wr_en;
    logic [2:0]              imm_src;
    logic                    alu_src;
    logic [1:0]              result_src;
    logic [3:0]              alu_control;
    logic                    pc_src;
    logic                    jalr;
    logic [3:0]              byte_en;
    logic                    alu_src_a_sel;
    logic                    signed_flag;

    assign instr       = imem_rdata_i;
    assign imem_addr_o = pc;
    assign dmem_addr_o = alu_result;                   // Effective address

    pc_unit u_pc (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pc_src_i    (pc_src),
        .jalr_i      (jalr),
        .imm_i       (imm),
        .alu_result_i(alu_result),
        .pc_o        (pc),
        .pc_plus4_o  (pc_plus4)
    );

    control_unit u_ctrl (
        .opcode_i       (instr.rsi.opcode),
        .funct3_i       (instr.rsi.funct3),
        .funct7_i       (instr.rsi.funct7),
        .zero_i         (zero),
        .alu_result_i   (alu_result),
        .reg_wr_en_o    (reg_wr_en),
        .mem_wr_en_o    (mem_wr_en),
        .imm_src_o      (imm_src),
        .alu_src_o      (alu_src),
        .result_src_o   (result_src),
        .alu_control_o  (alu_control),
        .pc_src_o       (pc_src),
        .jalr_o         (jalr),
        .byte_en_o      (byte_en),
        .alu_src_a_sel_o(alu_src_a_sel),
        .signed_o       (signed_flag)
    );

    reg_file u_rf (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .rs1_i   (instr.rsi.rs1),
        .rs2_i   (instr.rsi.rs2),
        .rd_i    (instr.rsi.rd),
        .wr_en_i (reg_wr_en),
        .wdata_i (result),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

    imm_gen u_imm (
        .instr_i  (instr),
        .imm_src_i(imm_src),
        .imm_o    (imm)
    );

    assign src_a = alu_src_a_sel ? pc : rdata1;        // AUIPC and JAL use pc
    assign src_b = alu_src ? imm : rdata2;

    alu u_alu (
        .a_i          (src_a),
        .b_i          (src_b),
        .alu_control_i(alu_control),
        .result_o     (alu_result),
        .zero_o       (zero)
    );

    load_store_unit u_lsu (
        .addr_i      (alu_result),
        .store_data_i(rdata2),
        .byte_en_i   (byte_en),
        .signed_i    (signed_flag),
        .mem_wr_en_i (mem_wr_en & ~reset_i),           // No store while in reset
        .dmem_rdata_i(dmem_rdata_i),
        .dmem_wdata_o(dmem_wdata_o),
        .dmem_be_o   (dmem_be_o),
        .dmem_we_o   (dmem_we_o),
        .load_data_o (load_data)
    );

    assign result = (result_src == rv_pkg::RES_MEM) ? load_data :
                    (result_src == rv_pkg::RES_PC4) ? pc_plus4 : alu_result;

endmodule

`default_nettype wire

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_tb;

    logic        clk_i;
    logic        reset_i;
    logic [31:0] imem_addr_o;
    logic [31:0] imem_rdata_i;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic [3:0]  dmem_be_o;
    logic        dmem_we_o;
    logic [31:0] dmem_rdata_i;

    typedef struct packed {
        logic [31:0] instr;                            // Word on the instruction port
        logic [31:0] ldata;                            // Word on the data read port
        logic [31:0] pc;                               // Expected fetch address
        logic        we;
        logic [31:0] addr;                             // Checked only for stores
        logic [31:0] wdata;
        logic [3:0]  be;
    } row_t;

    row_t  rows[$];
    string names[$];

    rv_core uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .imem_addr_o (imem_addr_o),
        .imem_rdata_i(imem_rdata_i),
        .dmem_addr_o (dmem_addr_o),
        .dmem_wdata_o(dmem_wdata_o),
        .dmem_be_o   (dmem_be_o),
        .dmem_we_o   (dmem_we_o),
        .dmem_rdata_i(dmem_rdata_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;                     // 8 ns period
    end

    initial begin
        repeat (16) @(posedge clk_i);                  // 16 cycles in reset
        @(negedge clk_i);
        reset_i = 1'b0;
    end

    // Instruction encoders taking register and immediate fields as plain ints
    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                           input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs1, input int rs2,
                                           input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rv_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OPC_JAL};
    endfunction

    task automatic add_row(input string name, input logic [31:0] instr,
                           input logic [31:0] ldata, input logic [31:0] pc, input int we,
                           input logic [31:0] addr, input logic [31:0] wdata, input int be);
        row_t r;
        r = '{instr, ldata, pc, we[0], addr, wdata, be[3:0]};
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %08h, actual %08h", name, what, expected, actual);
            stop_run();
        end
    endtask

    // x1=6, x2=-3, x3=0x12345000, x4=0x100 base, x6=0x12345678, x8=6
    task automatic fill_table();
        add_row("addi x1", i_type(6, 0, 0, 1, rv_pkg::OPC_OP_IMM), 0, 'h000, 0, 0, 0, 0);
        add_row("addi x2", i_type(-3, 0, 0, 2, rv_pkg::OPC_OP_IMM), 0, 'h004, 0, 0, 0, 0);
        add_row("lui x3", u_type('h12345, 3, rv_pkg::OPC_LUI), 0, 'h008, 0, 0, 0, 0);
        add_row("addi x4", i_type('h100, 0, 0, 4, rv_pkg::OPC_OP_IMM), 0, 'h00c, 0, 0, 0, 0);
        add_row("addi x6", i_type('h678, 3, 0, 6, rv_pkg::OPC_OP_IMM), 0, 'h010, 0, 0, 0, 0);
        add_row("addi x8", i_type(6, 0, 0, 8, rv_pkg::OPC_OP_IMM), 0, 'h014, 0, 0, 0, 0);
        add_row("sw lui", s_type(0, 3, 4, 2), 0, 'h018, 1, 'h100, 'h12345000, 'hf);
        // ALU result into x5, then SW x5 to the next word
        add_row("add", r_type(0, 2, 1, 0, 5), 0, 'h01c, 0, 0, 0, 0);
        add_row("sw add", s_type(4, 5, 4, 2), 0, 'h020, 1, 'h104, 'h00000003, 'hf);
        add_row("sub", r_type('h20, 2, 1, 0, 5), 0, 'h024, 0, 0, 0, 0);
        add_row("sw sub", s_type(8, 5, 4, 2), 0, 'h028, 1, 'h108, 'h00000009, 'hf);
        add_row("and", r_type(0, 2, 1, 7, 5), 0, 'h02c, 0, 0, 0, 0);
        add_row("sw and", s_type(12, 5, 4, 2), 0, 'h030, 1, 'h10c, 'h00000004, 'hf);
        add_row("or", r_type(0, 2, 1, 6, 5), 0, 'h034, 0, 0, 0, 0);
        add_row("sw or", s_type(16, 5, 4, 2), 0, 'h038, 1, 'h110, 'hffffffff, 'hf);
        add_row("xor", r_type(0, 2, 1, 4, 5), 0, 'h03c, 0, 0, 0, 0);
        add_row("sw xor", s_type(20, 5, 4, 2), 0, 'h040, 1, 'h114, 'hfffffffb, 'hf);
        add_row("sll", r_type(0, 1, 1, 1, 5), 0, 'h044, 0, 0, 0, 0);
        add_row("sw sll", s_type(24, 5, 4, 2), 0, 'h048, 1, 'h118, 'h00000180, 'hf);
        add_row("srl", r_type(0, 1, 2, 5, 5), 0, 'h04c, 0, 0, 0, 0);
        add_row("sw srl", s_type(28, 5, 4, 2), 0, 'h050, 1, 'h11c, 'h03ffffff, 'hf);
        add_row("sra", r_type('h20, 1, 2, 5, 5), 0, 'h054, 0, 0, 0, 0);
        add_row("sw sra", s_type(32, 5, 4, 2), 0, 'h058, 1, 'h120, 'hffffffff, 'hf);
        add_row("srai", i_type('h401, 2, 5, 5, rv_pkg::OPC_OP_IMM), 0, 'h05c, 0, 0, 0, 0);
        add_row("sw srai", s_type(36, 5, 4, 2), 0, 'h060, 1, 'h124, 'hfffffffe, 'hf);
        add_row("slt", r_type(0, 1, 2, 2, 5), 0, 'h064, 0, 0, 0, 0);
        add_row("sw slt", s_type(40, 5, 4, 2), 0, 'h068, 1, 'h128, 'h00000001, 'hf);
        add_row("sltu", r_type(0, 1, 2, 3, 5), 0, 'h06c, 0, 0, 0, 0);
        add_row("sw sltu", s_type(44, 5, 4, 2), 0, 'h070, 1, 'h12c, 'h00000000, 'hf);
        add_row("auipc", u_type(1, 5, rv_pkg::OPC_AUIPC), 0, 'h074, 0, 0, 0, 0);
        add_row("sw auipc", s_type(48, 5, 4, 2), 0, 'h078, 1, 'h130, 'h00001074, 'hf);
        // Narrow stores of x6 with data shifted to the addressed lane
        add_row("sb lane0", s_type('h40, 6, 4, 0), 0, 'h07c, 1, 'h140, 'h12345678, 'h1);
        add_row("sb lane1", s_type('h41, 6, 4, 0), 0, 'h080, 1, 'h141, 'h34567800, 'h2);
        add_row("sb lane2", s_type('h42, 6, 4, 0), 0, 'h084, 1, 'h142, 'h56780000, 'h4);
        add_row("sb lane3", s_type('h43, 6, 4, 0), 0, 'h088, 1, 'h143, 'h78000000, 'h8);
        add_row("sh lane0", s_type('h44, 6, 4, 1), 0, 'h08c, 1, 'h144, 'h12345678, 'h3);
        add_row("sh lane2", s_type('h46, 6, 4, 1), 0, 'h090, 1, 'h146, 'h56780000, 'hc);
        // Loads into x7 from word 8765c3a1 and stored back
        add_row("lb", i_type('h50, 4, 0, 7, rv_pkg::OPC_LOAD), 'h8765c3a1, 'h094, 0, 0, 0, 0);
        add_row("sw lb", s_type('h60, 7, 4, 2), 0, 'h098, 1, 'h160, 'hffffffa1, 'hf);
        add_row("lbu", i_type('h51, 4, 4, 7, rv_pkg::OPC_LOAD), 'h8765c3a1, 'h09c, 0, 0, 0, 0);
        add_row("sw lbu", s_type('h64, 7, 4, 2), 0, 'h0a0, 1, 'h164, 'h000000c3, 'hf);
        add_row("lb pos", i_type('h52, 4, 0, 7, rv_pkg::OPC_LOAD), 'h8765c3a1, 'h0a4, 0, 0, 0, 0);
        add_row("sw lb pos", s_type('h68, 7, 4, 2), 0, 'h0a8, 1, 'h168, 'h00000065, 'hf);
        add_row("lh", i_type('h52, 4, 1, 7, rv_pkg::OPC_LOAD), 'h8765c3a1, 'h0ac, 0, 0, 0, 0);
        add_row("sw lh", s_type('h6c, 7, 4, 2), 0, 'h0b0, 1, 'h16c, 'hffff8765, 'hf);
        add_row("lhu", i_type('h50, 4, 5, 7, rv_pkg::OPC_LOAD), 'h8765c3a1, 'h0b4, 0, 0, 0, 0);
        add_row("sw lhu", s_type('h70, 7, 4, 2), 0, 'h0b8, 1, 'h170, 'h0000c3a1, 'hf);
        add_row("lw", i_type('h54, 4, 2, 7, rv_pkg::OPC_LOAD), 'h8765c3a1, 'h0bc, 0, 0, 0, 0);
        add_row("sw lw", s_type('h74, 7, 4, 2), 0, 'h0c0, 1, 'h174, 'h8765c3a1, 'hf);
        // Branches taken and not taken
        add_row("beq taken", b_type(8, 1, 8, 0), 0, 'h0c4, 0, 0, 0, 0);
        add_row("beq not", b_type(8, 1, 2, 0), 0, 'h0cc, 0, 0, 0, 0);
        add_row("bne taken", b_type('h100, 1, 2, 1), 0, 'h0d0, 0, 0, 0, 0);
        add_row("bne not", b_type(8, 1, 8, 1), 0, 'h1d0, 0, 0, 0, 0);
        add_row("blt taken", b_type(-16, 2, 1, 4), 0, 'h1d4, 0, 0, 0, 0);   // Backward
        add_row("blt not", b_type(8, 1, 2, 4), 0, 'h1c4, 0, 0, 0, 0);
        add_row("bge taken", b_type(12, 1, 2, 5), 0, 'h1c8, 0, 0, 0, 0);
        add_row("bge not", b_type(8, 2, 1, 5), 0, 'h1d4, 0, 0, 0, 0);
        add_row("bltu taken", b_type('h7f0, 1, 2, 6), 0, 'h1d8, 0, 0, 0, 0);
        add_row("bltu not", b_type(8, 2, 1, 6), 0, 'h9c8, 0, 0, 0, 0);
        add_row("bgeu taken", b_type(-'h800, 2, 1, 7), 0, 'h9cc, 0, 0, 0, 0);
        add_row("bgeu not", b_type(8, 1, 2, 7), 0, 'h1cc, 0, 0, 0, 0);
        // Jumps with link registers exposed by SW
        add_row("jal", j_type('h20, 9), 0, 'h1d0, 0, 0, 0, 0);
        add_row("sw jal link", s_type('h78, 9, 4, 2), 0, 'h1f0, 1, 'h178, 'h000001d4, 'hf);
        add_row("jalr", i_type('h31, 4, 0, 10, rv_pkg::OPC_JALR), 0, 'h1f4, 0, 0, 0, 0);
        add_row("sw jalr link", s_type('h7c, 10, 4, 2), 0, 'h130, 1, 'h17c, 'h000001f8, 'hf);
        add_row("nop", i_type(0, 0, 0, 0, rv_pkg::OPC_OP_IMM), 0, 'h134, 0, 0, 0, 0);
    endtask

    initial begin
        int waited;
        waited       = 0;
        reset_i      = 1'b1;
        imem_rdata_i = s_type(0, 0, 0, 2);             // Store word while in reset
        dmem_rdata_i = '0;
        fill_table();
        while (reset_i !== 1'b0) begin
            @(negedge reset_i or posedge clk_i);
            waited++;
            assert (waited < 40) else begin
                $display("Reset was not released within 40 clock cycles");
                stop_run();
            end
            if (reset_i === 1'b1) begin
                compare_value("reset", "dmem_we_o", 32'd0, {31'b0, dmem_we_o});
            end
        end
        for (int i = 0; i < rows.size(); i++) begin
            if (i > 0) begin
                @(negedge clk_i);                      // One instruction per cycle
            end
            imem_rdata_i = rows[i].instr;
            dmem_rdata_i = rows[i].ldata;
            #2;                                        // Let the datapath settle
            compare_value(names[i], "pc", rows[i].pc, imem_addr_o);
            compare_value(names[i], "dmem_we_o", {31'b0, rows[i].we}, {31'b0, dmem_we_o});
            compare_value(names[i], "dmem_be_o", {28'b0, rows[i].be}, {28'b0, dmem_be_o});
            if (rows[i].we) begin
                compare_value(names[i], "dmem_addr_o", rows[i].addr, dmem_addr_o);
                compare_value(names[i], "dmem_wdata_o", rows[i].wdata, dmem_wdata_o);
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/rv_pkg.sv
logic/alu_decoder.sv
logic/main_decoder.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/alu.sv
logic/reg_file.sv
logic/load_store_unit.sv
logic/pc_unit.sv
logic/rv_core.sv
bench/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  # Package first, then the blocks, then the core
  - logic/rv_pkg.sv
  - logic/alu_decoder.sv
  - logic/main_decoder.sv
  - logic/control_unit.sv
  - logic/imm_gen.sv
  - logic/alu.sv
  - logic/reg_file.sv
  - logic/load_store_unit.sv
  - logic/pc_unit.sv
  - logic/rv_core.sv
  - target: test
    files:
      - bench/rv_core_tb.sv
